//--- src.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/excp_pkg.sv
rtl/excp_encoder.sv
rtl/mem_wb.sv
rtl/csr_excp_regs.sv
rtl/regfile.sv
rtl/commit_top.sv
tests/commit_sva.sv
tests/commit_tb.sv

//--- tests/commit_stim.txt
# kind val pc instr we waddr result excp ertn refetch llwe llval csrwe csrsel csrwdata stall flush raddr
# then expected: cvalid cpc era ecode esub badv vppn llbit rdata fetch_flush (c = check, r = random read)
c 1 1c000000 02800401 1 01 11111111 0000 0 0 0 0 0 6 0 0 0 01 0 0 0 0 0 0 0 0 0 0
c 1 1c000004 02800802 1 00 deadbeef 0000 0 0 0 0 0 6 0 0 0 01 1 1c000000 0 0 0 0 0 0 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 01 1 1c000004 0 0 0 0 0 0 11111111 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 00 0 0 0 0 0 0 0 0 0 0
r 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 00 0 0 0 0 0 0 0 0 0 0
c 1 1c000010 02800c03 1 02 22222222 0002 0 0 0 0 0 6 0 0 0 02 0 0 0 0 0 0 0 0 0 0
c 1 1c000014 02801004 0 00 0 0008 0 0 0 0 0 6 0 0 0 02 0 0 1c000010 08 0 1c000010 0 0 0 0
c 1 1c000018 28801005 1 05 a0b0c123 0800 0 0 0 0 0 6 0 0 0 00 0 0 1c000014 03 0 1c000014 0e000 0 0 0
c 1 1c00001c 29801006 1 03 12345678 9400 0 0 0 0 0 6 0 0 0 00 0 0 1c000018 3f 0 a0b0c123 50586 0 0 0
c 1 1c000020 002b0000 0 00 0 0220 0 0 0 0 0 6 0 0 0 03 0 0 1c00001c 08 1 12345678 50586 0 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 03 0 0 1c000020 0b 0 12345678 50586 0 0 0
c 1 1c000024 20000005 1 04 44444444 0000 0 0 1 1 0 6 0 0 0 04 0 0 1c000020 0b 0 12345678 50586 0 0 0
c 1 1c000028 02801406 1 05 55555555 0000 0 1 0 0 0 6 0 0 1 04 1 1c000024 1c000020 0b 0 12345678 50586 0 0 1
c 1 1c00002c 06483800 0 00 0 0000 1 0 0 0 0 6 0 0 0 05 0 0 1c000020 0b 0 12345678 50586 1 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 04 0 0 1c000020 0b 0 12345678 50586 0 44444444 0
c 1 1c000030 02801807 1 06 66666666 0000 0 0 0 0 0 6 0 0 0 06 0 0 1c000020 0b 0 12345678 50586 0 0 0
c 1 1c000034 02801c08 1 07 77777777 0000 0 0 0 0 0 6 0 1 0 06 1 1c000030 1c000020 0b 0 12345678 50586 0 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 06 0 0 1c000020 0b 0 12345678 50586 0 66666666 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 07 0 0 1c000020 0b 0 12345678 50586 0 0 0
c 1 1c000038 04001809 0 00 0 0000 0 0 0 0 1 6 abcd0000 0 0 00 0 0 1c000020 0b 0 12345678 50586 0 0 0
c 1 1c00003c 04001c0a 0 00 0 0000 0 0 0 0 1 7 bad00bad 0 0 00 1 1c000038 1c000020 0b 0 12345678 50586 0 0 0
c 1 1c000040 0280200b 0 00 0 0001 0 0 0 0 0 6 0 0 0 00 1 1c00003c abcd0000 0b 0 12345678 50586 0 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 00 0 0 1c000040 00 0 12345678 50586 0 0 0
c 1 1c000044 04001c0c 0 00 0 0000 0 0 0 0 1 7 bad00bad 0 0 00 0 0 1c000040 00 0 12345678 50586 0 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 00 1 1c000044 1c000040 00 0 12345678 50586 0 0 0
c 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 00 0 0 1c000040 00 0 bad00bad 50586 0 0 0
r 0 0 0 0 00 0 0000 0 0 0 0 0 6 0 0 0 00 0 0 0 0 0 0 0 0 0 0

//--- tests/commit_tb.sv
`include "commit_settings.svh"

module commit_tb;

    localparam int MAX_LINES = 64;
    localparam int NUM_FIELDS = 27;

    logic clk;
    logic rst_n_i;
    logic mem_valid_i, mem_we_i, mem_ertn_i, mem_refetch_i;
    logic mem_llbit_we_i, mem_llbit_value_i, mem_csr_we_i, stall_i, flush_i;
    logic [`XLEN-1:0] mem_pc_i, mem_instr_i, mem_csr_wdata_i;
    logic [`REG_ADDR_W-1:0] mem_waddr_i, rf_raddr_i;
    wb_pkg::mem_result_u mem_result_i;
    logic [`EXCP_W-1:0] mem_excp_num_i;
    wb_pkg::csr_sel_e mem_csr_sel_i;
    logic commit_valid_o, excp_flush_o, ertn_flush_o, fetch_flush_o, tlbrefill_o, llbit_o;
    logic [`XLEN-1:0] commit_pc_o, commit_instr_o, csr_era_o, csr_badv_o, rf_rdata_o;
    excp_pkg::ecode_e csr_ecode_o;
    logic [8:0] csr_esubcode_o;
    logic [`VPPN_W-1:0] csr_vppn_o;

    logic [31:0] fld [MAX_LINES][NUM_FIELDS]; // Inputs 0..16, expected 17..26.
    byte kind [MAX_LINES];
    logic [31:0] shadow [32];                 // Register file reference model.
    logic [4:0] rd_addr;
    int nl = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;
    int sva_fails = 0;
    bit loaded;

    commit_top commit_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_stim(output bit ok);
        int fd;
        int cnt;
        string line;
        fd = $fopen("tests/commit_stim.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd) && nl < MAX_LINES) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 2 && line[0] != "#") begin
                kind[nl] = line[0];
                cnt = $sscanf(line.substr(2, line.len() - 1),
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[nl][0], fld[nl][1], fld[nl][2], fld[nl][3], fld[nl][4],
                    fld[nl][5], fld[nl][6], fld[nl][7], fld[nl][8], fld[nl][9],
                    fld[nl][10], fld[nl][11], fld[nl][12], fld[nl][13], fld[nl][14],
                    fld[nl][15], fld[nl][16], fld[nl][17], fld[nl][18], fld[nl][19],
                    fld[nl][20], fld[nl][21], fld[nl][22], fld[nl][23], fld[nl][24],
                    fld[nl][25], fld[nl][26]);
                if (cnt == NUM_FIELDS) nl++;
            end
        end
        if (ok) $fclose(fd);
    endtask

    task automatic drive_line(input int i);
        mem_valid_i       <= fld[i][0][0];
        mem_pc_i          <= fld[i][1];
        mem_instr_i       <= fld[i][2];
        mem_we_i          <= fld[i][3][0];
        mem_waddr_i       <= fld[i][4][4:0];
        mem_result_i      <= fld[i][5];
        mem_excp_num_i    <= fld[i][6][15:0];
        mem_ertn_i        <= fld[i][7][0];
        mem_refetch_i     <= fld[i][8][0];
        mem_llbit_we_i    <= fld[i][9][0];
        mem_llbit_value_i <= fld[i][10][0];
        mem_csr_we_i      <= fld[i][11][0];
        mem_csr_sel_i     <= wb_pkg::csr_sel_e'(fld[i][12][13:0]);
        mem_csr_wdata_i   <= fld[i][13];
        stall_i           <= fld[i][14][0];
        flush_i           <= fld[i][15][0];
        rd_addr = (kind[i] == "r") ? 5'($urandom % 32) : fld[i][16][4:0];
        rf_raddr_i        <= rd_addr;
    endtask

    // A line commits a register write if it is valid, unsquashed and not stalled.
    function automatic bit writes_reg(input int i);
        return fld[i][0][0] && fld[i][3][0] && fld[i][4][4:0] != 0 && fld[i][6] == 0
            && !fld[i][7][0] && !fld[i][14][0] && !fld[i][15][0];
    endfunction

    // Refill is flagged only when a TLB refill bit is the highest-priority cause.
    function automatic bit expect_refill(input logic [15:0] vec);
        logic [15:0] lowest;
        lowest = vec & (~vec + 16'd1);
        return lowest == 16'h0004 || lowest == 16'h0800;
    endfunction

    task automatic compare(input string name, input int i, input logic [31:0] exp,
                           input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s at line %0d: expected %h, actual %h", name, i, exp, act);
        end
    endtask

    task automatic check_line(input int i);
        if (kind[i] == "r") begin
            compare("random_read", i, shadow[rd_addr], rf_rdata_o);
        end else begin
            compare("commit_valid", i, fld[i][17], 32'(commit_valid_o));
            compare("commit_pc", i, fld[i][18], commit_pc_o);
            compare("csr_era", i, fld[i][19], csr_era_o);
            compare("csr_ecode", i, fld[i][20], 32'(csr_ecode_o));
            compare("csr_esubcode", i, fld[i][21], 32'(csr_esubcode_o));
            compare("csr_badv", i, fld[i][22], csr_badv_o);
            compare("csr_vppn", i, fld[i][23], 32'(csr_vppn_o));
            compare("llbit", i, fld[i][24], 32'(llbit_o));
            compare("rf_rdata", i, fld[i][25], rf_rdata_o);
            compare("fetch_flush", i, fld[i][26], 32'(fetch_flush_o));
            compare("excp_flush", i, 32'(fld[i][6] != 0), 32'(excp_flush_o));
            compare("ertn_flush", i, 32'(fld[i][7][0]), 32'(ertn_flush_o));
            compare("tlbrefill", i, 32'(expect_refill(fld[i][6][15:0])), 32'(tlbrefill_o));
            if (fld[i][17][0] && i > 0) compare("commit_instr", i, fld[i-1][2], commit_instr_o);
        end
    endtask

    initial begin
        void'($urandom(63282));
        rst_n_i = 1'b0;
        {mem_valid_i, mem_we_i, mem_ertn_i, mem_refetch_i, mem_llbit_we_i} = '0;
        {mem_llbit_value_i, mem_csr_we_i, stall_i, flush_i} = '0;
        {mem_pc_i, mem_instr_i, mem_csr_wdata_i, mem_result_i} = '0;
        {mem_waddr_i, rf_raddr_i, mem_excp_num_i} = '0;
        mem_csr_sel_i = wb_pkg::CSR_ERA;
        foreach (shadow[r]) shadow[r] = '0;
        load_stim(loaded);
        if (!loaded || nl == 0) begin
            $display("Could not read any stimulus from tests/commit_stim.txt");
            $display("Test failed");
            $finish;
        end else begin
            limit = nl + 20;
            repeat (4) @(posedge clk);
            rst_n_i <= 1'b1;
            for (int i = 0; i < nl; i++) begin
                @(posedge clk);
                drive_line(i);
                if (i >= 2 && writes_reg(i - 2)) shadow[fld[i-2][4][4:0]] = fld[i-2][5];
                @(negedge clk);
                check_line(i);
            end
            repeat (2) @(posedge clk);
            @(negedge clk);
            sva_fails = commit_top_inst.commit_sva_inst.fail_count;
            $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                     checks, errors, sva_fails);
            if (errors == 0 && sva_fails == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit + 4) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

endmodule

//--- tests/commit_sva.sv
module commit_sva (
    input logic               clk,
    input logic               rst_n_i,
    input logic               stall_i,
    input logic               flush_i,
    input logic               mem_ertn_i,
    input logic               excp_flush_o,
    input logic               tlbrefill_o,
    input logic [31:0]        mem_pc_i,
    input logic               commit_valid_o,
    input logic [31:0]        csr_era_o,
    input excp_pkg::ecode_e   csr_ecode_o
);

    int fail_count = 0;

    // A squashed instruction never reaches commit.
    squash_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        (flush_i || excp_flush_o || mem_ertn_i) |=> !commit_valid_o)
        else begin
            fail_count++;
            $error("commit_valid_o high after a squash");
        end

    era_capture: assert property (@(posedge clk) disable iff (!rst_n_i)
        excp_flush_o |=> csr_era_o == $past(mem_pc_i))
        else begin
            fail_count++;
            $error("ERA does not hold the pc of the excepting instruction");
        end

    stall_no_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> !commit_valid_o)
        else begin
            fail_count++;
            $error("commit_valid_o high after a stall cycle");
        end

    refill_cause: assert property (@(posedge clk) disable iff (!rst_n_i)
        tlbrefill_o |=> csr_ecode_o == excp_pkg::TLBR)
        else begin
            fail_count++;
            $error("TLB refill did not load the TLBR cause");
        end

endmodule

bind commit_top commit_sva commit_sva_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .stall_i        (stall_i),
    .flush_i        (flush_i),
    .mem_ertn_i     (mem_ertn_i),
    .excp_flush_o   (excp_flush_o),
    .tlbrefill_o    (tlbrefill_o),
    .mem_pc_i       (mem_pc_i),
    .commit_valid_o (commit_valid_o),
    .csr_era_o      (csr_era_o),
    .csr_ecode_o    (csr_ecode_o)
);

//--- rtl/commit_top.sv
`include "commit_settings.svh"

module commit_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   mem_valid_i,
    input  logic [`XLEN-1:0]       mem_pc_i,
    input  logic [`XLEN-1:0]       mem_instr_i,
    input  logic                   mem_we_i,
    input  logic [`REG_ADDR_W-1:0] mem_waddr_i,
    input  wb_pkg::mem_result_u    mem_result_i,
    input  logic [`EXCP_W-1:0]     mem_excp_num_i,
    input  logic                   mem_ertn_i,
    input  logic                   mem_refetch_i,
    input  logic                   mem_llbit_we_i,
    input  logic                   mem_llbit_value_i,
    input  logic                   mem_csr_we_i,
    input  wb_pkg::csr_sel_e       mem_csr_sel_i,
    input  logic [`XLEN-1:0]       mem_csr_wdata_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    output logic                   commit_valid_o,
    output logic [`XLEN-1:0]       commit_pc_o,
    output logic [`XLEN-1:0]       commit_instr_o,
    output logic                   excp_flush_o,
    output logic                   ertn_flush_o,
    output logic                   fetch_flush_o,
    output logic                   tlbrefill_o,
    output logic [`XLEN-1:0]       csr_era_o,
    output excp_pkg::ecode_e       csr_ecode_o,
    output logic [8:0]             csr_esubcode_o,
    output logic [`XLEN-1:0]       csr_badv_o,
    output logic [`VPPN_W-1:0]     csr_vppn_o,
    output logic                   llbit_o,
    input  logic [`REG_ADDR_W-1:0] rf_raddr_i,
    output logic [`XLEN-1:0]       rf_rdata_o
);

    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_waddr;
    logic [`XLEN-1:0]       wb_wdata;
    logic                   wb_llbit_we;
    logic                   wb_llbit_value;
    logic                   wb_csr_we;
    wb_pkg::csr_sel_e       wb_csr_sel;
    logic [`XLEN-1:0]       wb_csr_wdata;
    excp_pkg::ecode_e       ecode;
    logic [8:0]             esubcode;
    logic                   badv_we;
    logic [`XLEN-1:0]       badv;
    logic                   tlb_we;
    logic [`VPPN_W-1:0]     vppn;

    excp_encoder excp_encoder_inst (
        .excp_num_i  (mem_excp_num_i),
        .pc_i        (mem_pc_i),
        .result_i    (mem_result_i),
        .excp_o      (excp_flush_o),
        .ecode_o     (ecode),
        .esubcode_o  (esubcode),
        .badv_we_o   (badv_we),
        .badv_o      (badv),
        .tlb_we_o    (tlb_we),
        .vppn_o      (vppn),
        .tlbrefill_o (tlbrefill_o)
    );

    mem_wb mem_wb_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .mem_valid_i       (mem_valid_i),
        .mem_pc_i          (mem_pc_i),
        .mem_instr_i       (mem_instr_i),
        .mem_we_i          (mem_we_i),
        .mem_waddr_i       (mem_waddr_i),
        .mem_result_i      (mem_result_i),
        .mem_ertn_i        (mem_ertn_i),
        .mem_refetch_i     (mem_refetch_i),
        .mem_llbit_we_i    (mem_llbit_we_i),
        .mem_llbit_value_i (mem_llbit_value_i),
        .mem_csr_we_i      (mem_csr_we_i),
        .mem_csr_sel_i     (mem_csr_sel_i),
        .mem_csr_wdata_i   (mem_csr_wdata_i),
        .excp_i            (excp_flush_o),
        .ertn_flush_o      (ertn_flush_o),
        .fetch_flush_o     (fetch_flush_o),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .commit_instr_o    (commit_instr_o),
        .wb_we_o           (wb_we),
        .wb_waddr_o        (wb_waddr),
        .wb_wdata_o        (wb_wdata),
        .wb_llbit_we_o     (wb_llbit_we),
        .wb_llbit_value_o  (wb_llbit_value),
        .wb_csr_we_o       (wb_csr_we),
        .wb_csr_sel_o      (wb_csr_sel),
        .wb_csr_wdata_o    (wb_csr_wdata)
    );

    csr_excp_regs csr_excp_regs_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .excp_i        (excp_flush_o),
        .ecode_i       (ecode),
        .esubcode_i    (esubcode),
        .badv_we_i     (badv_we),
        .badv_i        (badv),
        .tlb_we_i      (tlb_we),
        .vppn_i        (vppn),
        .pc_i          (mem_pc_i),
        .ertn_i        (mem_ertn_i),
        .llbit_we_i    (wb_llbit_we),
        .llbit_value_i (wb_llbit_value),
        .csr_we_i      (wb_csr_we),
        .csr_sel_i     (wb_csr_sel),
        .csr_wdata_i   (wb_csr_wdata),
        .era_o         (csr_era_o),
        .ecode_o       (csr_ecode_o),
        .esubcode_o    (csr_esubcode_o),
        .badv_o        (csr_badv_o),
        .vppn_o        (csr_vppn_o),
        .llbit_o       (llbit_o)
    );

    regfile regfile_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_we),
        .waddr_i (wb_waddr),
        .wdata_i (wb_wdata),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

//--- rtl/regfile.sv
`include "commit_settings.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`REG_ADDR_W-1:0] raddr_i,
    output logic [`XLEN-1:0]       rdata_o
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= `ZERO_WORD;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired to zero.
    assign rdata_o = (raddr_i == '0) ? `ZERO_WORD : regs[raddr_i];

endmodule

//--- rtl/csr_excp_regs.sv
`include "commit_settings.svh"

module csr_excp_regs (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               excp_i,
    input  excp_pkg::ecode_e   ecode_i,
    input  logic [8:0]         esubcode_i,
    input  logic               badv_we_i,
    input  logic [`XLEN-1:0]   badv_i,
    input  logic               tlb_we_i,
    input  logic [`VPPN_W-1:0] vppn_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic               ertn_i,
    input  logic               llbit_we_i,
    input  logic               llbit_value_i,
    input  logic               csr_we_i,
    input  wb_pkg::csr_sel_e   csr_sel_i,
    input  logic [`XLEN-1:0]   csr_wdata_i,
    output logic [`XLEN-1:0]   era_o,
    output excp_pkg::ecode_e   ecode_o,
    output logic [8:0]         esubcode_o,
    output logic [`XLEN-1:0]   badv_o,
    output logic [`VPPN_W-1:0] vppn_o,
    output logic               llbit_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            era_o      <= `ZERO_WORD;
            ecode_o    <= excp_pkg::INT;
            esubcode_o <= 9'd0;
            badv_o     <= `ZERO_WORD;
            vppn_o     <= '0;
        end else if (excp_i) begin
            // Exception entry blocks the write port this edge.
            era_o      <= pc_i;
            ecode_o    <= ecode_i;
            esubcode_o <= esubcode_i;
            if (badv_we_i) begin
                badv_o <= badv_i;
            end
            if (tlb_we_i) begin
                vppn_o <= vppn_i;
            end
        end else if (csr_we_i) begin
            case (csr_sel_i)
                wb_pkg::CSR_ERA:  era_o  <= csr_wdata_i;
                wb_pkg::CSR_BADV: badv_o <= csr_wdata_i;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            llbit_o <= 1'b0;
        end else if (ertn_i) begin
            llbit_o <= 1'b0;              // ertn drops any reservation.
        end else if (llbit_we_i) begin
            llbit_o <= llbit_value_i;
        end
    end

endmodule

//--- rtl/mem_wb.sv
`include "commit_settings.svh"

module mem_wb (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   mem_valid_i,
    input  logic [`XLEN-1:0]       mem_pc_i,
    input  logic [`XLEN-1:0]       mem_instr_i,
    input  logic                   mem_we_i,
    input  logic [`REG_ADDR_W-1:0] mem_waddr_i,
    input  wb_pkg::mem_result_u    mem_result_i,
    input  logic                   mem_ertn_i,
    input  logic                   mem_refetch_i,
    input  logic                   mem_llbit_we_i,
    input  logic                   mem_llbit_value_i,
    input  logic                   mem_csr_we_i,
    input  wb_pkg::csr_sel_e       mem_csr_sel_i,
    input  logic [`XLEN-1:0]       mem_csr_wdata_i,
    input  logic                   excp_i,
    output logic                   ertn_flush_o,
    output logic                   fetch_flush_o,
    output logic                   commit_valid_o,
    output logic [`XLEN-1:0]       commit_pc_o,
    output logic [`XLEN-1:0]       commit_instr_o,
    output logic                   wb_we_o,
    output logic [`REG_ADDR_W-1:0] wb_waddr_o,
    output logic [`XLEN-1:0]       wb_wdata_o,
    output logic                   wb_llbit_we_o,
    output logic                   wb_llbit_value_o,
    output logic                   wb_csr_we_o,
    output wb_pkg::csr_sel_e       wb_csr_sel_o,
    output logic [`XLEN-1:0]       wb_csr_wdata_o
);

    logic squash;

    assign squash        = flush_i || excp_i || mem_ertn_i;
    assign ertn_flush_o  = mem_ertn_i;    // Same-cycle redirect.
    assign fetch_flush_o = mem_refetch_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || squash) begin
            // Bubble.
            commit_valid_o   <= 1'b0;
            commit_pc_o      <= `ZERO_WORD;
            commit_instr_o   <= `ZERO_WORD;
            wb_we_o          <= 1'b0;
            wb_waddr_o       <= '0;
            wb_wdata_o       <= `ZERO_WORD;
            wb_llbit_we_o    <= 1'b0;
            wb_llbit_value_o <= 1'b0;
            wb_csr_we_o      <= 1'b0;
            wb_csr_sel_o     <= wb_pkg::CSR_ERA;
            wb_csr_wdata_o   <= `ZERO_WORD;
        end else if (stall_i) begin
            // Write fields hold, so the writes repeat with the same value.
            commit_valid_o <= 1'b0;
            commit_pc_o    <= `ZERO_WORD;
            commit_instr_o <= `ZERO_WORD;
        end else begin
            commit_valid_o   <= mem_valid_i;
            commit_pc_o      <= mem_pc_i;
            commit_instr_o   <= mem_instr_i;
            wb_we_o          <= mem_we_i && mem_valid_i;
            wb_waddr_o       <= mem_waddr_i;
            wb_wdata_o       <= mem_result_i.data;
            wb_llbit_we_o    <= mem_llbit_we_i;
            wb_llbit_value_o <= mem_llbit_value_i;
            wb_csr_we_o      <= mem_csr_we_i;
            wb_csr_sel_o     <= mem_csr_sel_i;
            wb_csr_wdata_o   <= mem_csr_wdata_i;
        end
    end

endmodule

//--- rtl/excp_encoder.sv
`include "commit_settings.svh"

module excp_encoder (
    input  logic [`EXCP_W-1:0]  excp_num_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  wb_pkg::mem_result_u result_i,
    output logic                excp_o,
    output excp_pkg::ecode_e    ecode_o,
    output logic [8:0]          esubcode_o,
    output logic                badv_we_o,
    output logic [`XLEN-1:0]    badv_o,
    output logic                tlb_we_o,
    output logic [`VPPN_W-1:0]  vppn_o,
    output logic                tlbrefill_o
);

    localparam int IDX_W = $clog2(`EXCP_W);

    logic [IDX_W-1:0] idx;
    logic             fetch_addr;
    logic             data_addr;

    assign excp_o = |excp_num_i;

    // Lowest set bit wins.
    always_comb begin
        idx = '0;
        for (int i = `EXCP_W - 1; i >= 0; i--) begin
            if (excp_num_i[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        esubcode_o = 9'd0;
        case (idx)
            excp_pkg::EXCP_INT:    ecode_o = excp_pkg::INT;
            excp_pkg::EXCP_ADEF: begin
                ecode_o    = excp_pkg::ADE;
                esubcode_o = excp_pkg::ESUB_ADEF;
            end
            excp_pkg::EXCP_TLBR_F: ecode_o = excp_pkg::TLBR;
            excp_pkg::EXCP_PIF:    ecode_o = excp_pkg::PIF;
            excp_pkg::EXCP_PPI_F:  ecode_o = excp_pkg::PPI;
            excp_pkg::EXCP_SYS:    ecode_o = excp_pkg::SYS;
            excp_pkg::EXCP_BRK:    ecode_o = excp_pkg::BRK;
            excp_pkg::EXCP_INE:    ecode_o = excp_pkg::INE;
            excp_pkg::EXCP_IPE:    ecode_o = excp_pkg::IPE;
            excp_pkg::EXCP_ALE:    ecode_o = excp_pkg::ALE;
            excp_pkg::EXCP_ADEM: begin
                ecode_o    = excp_pkg::ADE;
                esubcode_o = excp_pkg::ESUB_ADEM;
            end
            excp_pkg::EXCP_TLBR_D: ecode_o = excp_pkg::TLBR;
            excp_pkg::EXCP_PME:    ecode_o = excp_pkg::PME;
            excp_pkg::EXCP_PPI_D:  ecode_o = excp_pkg::PPI;
            excp_pkg::EXCP_PIS:    ecode_o = excp_pkg::PIS;
            default:               ecode_o = excp_pkg::PIL;
        endcase
    end

    // Fetch causes fault on the pc, data causes on the result address.
    assign fetch_addr = excp_o &&
                        (idx inside {[excp_pkg::EXCP_ADEF:excp_pkg::EXCP_PPI_F]});
    assign data_addr  = excp_o && (idx >= excp_pkg::EXCP_ALE);

    assign badv_we_o = fetch_addr || data_addr;
    assign badv_o    = fetch_addr ? pc_i :
                       data_addr  ? result_i.data : `ZERO_WORD;

    // ADEF and ADEM have no translation behind them.
    assign tlb_we_o = badv_we_o && idx != excp_pkg::EXCP_ADEF && idx != excp_pkg::EXCP_ALE
                      && idx != excp_pkg::EXCP_ADEM;
    assign vppn_o   = fetch_addr ? pc_i[`XLEN-1 -: `VPPN_W] :
                      data_addr  ? result_i.addr.vppn : '0;

    assign tlbrefill_o = excp_o &&
                         (idx == excp_pkg::EXCP_TLBR_F || idx == excp_pkg::EXCP_TLBR_D);

endmodule

//--- rtl/excp_pkg.sv
package excp_pkg;

    // ESTAT.Ecode values.
    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADE  = 6'h08,
        ALE  = 6'h09,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        IPE  = 6'h0e,
        TLBR = 6'h3f
    } ecode_e;

    localparam logic [8:0] ESUB_ADEF = 9'd0;
    localparam logic [8:0] ESUB_ADEM = 9'd1;

    // Exception vector bit positions, lowest has priority.
    localparam int EXCP_INT    = 0;
    localparam int EXCP_ADEF   = 1;
    localparam int EXCP_TLBR_F = 2;  // Fetch TLB refill.
    localparam int EXCP_PIF    = 3;
    localparam int EXCP_PPI_F  = 4;  // Fetch privilege.
    localparam int EXCP_SYS    = 5;
    localparam int EXCP_BRK    = 6;
    localparam int EXCP_INE    = 7;
    localparam int EXCP_IPE    = 8;
    localparam int EXCP_ALE    = 9;
    localparam int EXCP_ADEM   = 10;
    localparam int EXCP_TLBR_D = 11; // Data TLB refill.
    localparam int EXCP_PME    = 12;
    localparam int EXCP_PPI_D  = 13; // Data privilege.
    localparam int EXCP_PIS    = 14;
    localparam int EXCP_PIL    = 15;

endpackage

//--- rtl/wb_pkg.sv
`include "commit_settings.svh"

package wb_pkg;

    localparam int OFFSET_W = `XLEN - `VPPN_W; // Page offset bits.

    // Faulting virtual address as seen by the TLB.
    typedef struct packed {
        logic [`VPPN_W-1:0]  vppn;
        logic [OFFSET_W-1:0] offset;
    } vaddr_t;

    // Memory-stage result: write data, or the bad address on a memory exception.
    typedef union packed {
        logic [`XLEN-1:0] data;
        vaddr_t           addr;
    } mem_result_u;

    // Target of the CSR write port, encoded as the CSR number.
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_ERA  = `CSR_ERA_ADDR,
        CSR_BADV = `CSR_BADV_ADDR
    } csr_sel_e;

endpackage

//--- rtl/commit_settings.svh
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

// Architectural widths.
`define XLEN        32
`define REG_ADDR_W  5
`define EXCP_W      16
`define CSR_ADDR_W  14
`define VPPN_W      19

// CSR numbers reachable through the write port.
`define CSR_ERA_ADDR  14'h006
`define CSR_BADV_ADDR 14'h007

`define ZERO_WORD 32'h0000_0000

`endif
